// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail is read from the log
set -e

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

grep -q "^Test passed$" sim.log

// ==== sim/tb_clock.sv ====
// Testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ns

module tb_clock #(
	parameter int HALF_PERIOD_NS = 2,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_48m,
	output logic rst_n_o
);

	// Free running clock, 4 ns period
	initial begin
		clk_48m = 1'b0;
		forever #HALF_PERIOD_NS clk_48m = ~clk_48m;
	end

	// Reset is held over the first rising edges and released on a falling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_48m);
		@(negedge clk_48m);
		rst_n_o = 1'b1;
	end

endmodule

// ==== sim/tb_top.sv ====
// Testbench top that drives the core as the CPU would and checks it against a beam reference model
`timescale 1ns/1ns

`include "ark_defines.svh"

module tb_top import ark_video_pkg::*, ark_cpu_pkg::*; ();

	// One frame is 264 lines of 384 pixel steps of 8 clocks
	localparam int LINE_CLKS = 384 * 8;
	localparam int FRAME_CLKS = 264 * LINE_CLKS;
	// The interrupt and watchdog tests need about seven frames and one more is slack
	localparam int TIMEOUT_CLKS = 8 * FRAME_CLKS;

	logic clk_48m;
	logic rst_n;
	cpu_bus_t bus;
	ctrl_in_t ctrl;
	logic [7:0] cpu_rdata;
	logic cpu_wait_n;
	logic cpu_int_n;
	logic cpu_reset_n;
	sync_out_t sync_w;
	gfx_addr_t gfx_w;

	// Reference beam state
	logic [2:0] m_div;
	beam_cnt_t m_h;
	beam_cnt_t m_v;
	logic m_nvb;

	logic [15:0] vmem [1024];
	logic vram_access;
	logic tile_en;
	logic tb_hflip;
	logic tb_vflip;
	int errors;
	int checks;
	int tests;
	int tile_checks;
	int cycles;

	tb_clock tb_clock_i (
		.clk_48m(clk_48m),
		.rst_n_o(rst_n)
	);

	arkanoid_core #(
		.WDOG_BITS(3)
	) arkanoid_core_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n),
		.v_center_i(3'd0),
		.bus_i(bus),
		.ctrl_i(ctrl),
		.cpu_rdata_o(cpu_rdata),
		.cpu_wait_n_o(cpu_wait_n),
		.cpu_int_n_o(cpu_int_n),
		.cpu_reset_n_o(cpu_reset_n),
		.sync_o(sync_w),
		.gfx_addr_o(gfx_w)
	);

	// ============================================================
	// Reference model and checks
	// ============================================================

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			errors++;
		end
	endtask

	// Beam counts from reset and a game vblank that falls at line 496 and returns at line 272
	always @(posedge clk_48m) begin
		if (!rst_n) begin
			m_div <= 3'd0;
			m_h <= 9'd128;
			m_v <= 9'd248;
			m_nvb <= 1'b1;
		end else begin
			m_div <= m_div + 3'd1;
			if (m_div == `ARK_PIX_PHASE) begin
				m_h <= (m_h == 9'd511) ? 9'd128 : m_h + 9'd1;
				if (m_h == 9'd128) begin
					m_v <= (m_v == 9'd511) ? 9'd248 : m_v + 9'd1;
				end
			end
			if (m_v == 9'd496) begin
				m_nvb <= 1'b0;
			end else if (m_v == 9'd272) begin
				m_nvb <= 1'b1;
			end
		end
	end

	// All checks here see the values from just before the edge
	always @(posedge clk_48m) begin
		logic hs;
		logic vs;
		beam_cnt_t prev_h;
		beam_cnt_t hx;
		beam_cnt_t vx;
		logic [9:0] wa;
		if (rst_n) begin
			hs = !m_h[8] && (m_h[6:0] > 7'd47) && (m_h[6:0] < 7'd80);
			vs = !((m_v >= 9'd248) && (m_v <= 9'd255));
			check_val("hsync", 16'(hs), 16'(sync_w.hsync));
			check_val("vsync", 16'(vs), 16'(sync_w.vsync));
			check_val("csync", 16'(hs ^ vs), 16'(sync_w.csync));
			check_val("hblank", 16'((m_h > 9'd137) && (m_h < 9'd266)), 16'(sync_w.hblank));
			check_val("vblank", 16'((m_v < 9'd271) || (m_v > 9'd495)), 16'(sync_w.vblank));
			// Wait only while a video RAM access meets the fetcher's odd slot
			check_val("cpu_wait_n_o", 16'(!(vram_access && m_h[0])), 16'(cpu_wait_n));
			// Two clocks after h turns even the new graphics address is out
			if (tile_en && m_div == 3'd6 && !m_h[0] && m_h[8]) begin
				prev_h = m_h - 9'd1;
				hx = prev_h ^ {9{tb_hflip}};
				vx = m_v ^ {9{tb_vflip}};
				wa = prev_h[8] ? {vx[7:3], hx[7:3]} : 10'd0;
				check_val("gfx_addr_o.code", 16'(vmem[wa][10:0]), 16'(gfx_w.code));
				check_val("gfx_addr_o.line", 16'(vx[2:0]), 16'(gfx_w.line));
				tile_checks++;
			end
		end
	end

	// Hang guard
	always @(posedge clk_48m) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CLKS) begin
			$display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLKS);
			$display("Test failed");
			$finish;
		end
	end

	// ============================================================
	// CPU bus model
	// ============================================================

	// Holds the access until a pixel step with wait high and returns read data one step later
	task automatic bus_access(input logic [15:0] addr, input logic [7:0] wdata,
			input logic is_wr, output logic [7:0] rdata);
		@(negedge clk_48m);
		bus.addr = addr;
		bus.wdata = wdata;
		bus.rd = !is_wr;
		bus.wr = is_wr;
		vram_access = (addr[15:12] == `ARK_REG_VRAM);
		do @(posedge clk_48m); while (!(m_div == `ARK_PIX_PHASE && cpu_wait_n));
		if (!is_wr) begin
			do @(posedge clk_48m); while (m_div != `ARK_PIX_PHASE);
		end
		@(negedge clk_48m);
		rdata = cpu_rdata;
		bus.rd = 1'b0;
		bus.wr = 1'b0;
		vram_access = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] wdata);
		logic [7:0] unused;
		bus_access(addr, wdata, 1'b1, unused);
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] rdata);
		bus_access(addr, 8'h00, 1'b0, rdata);
	endtask

	task automatic pulse_iack();
		@(negedge clk_48m);
		bus.iack = 1'b1;
		@(negedge clk_48m);
		bus.iack = 1'b0;
	endtask

	// Leaves the caller at the first edge with the new vblank level
	task automatic wait_nvb_rise();
		while (m_nvb) @(posedge clk_48m);
		while (!m_nvb) @(posedge clk_48m);
	endtask

	task automatic wait_nvb_fall();
		while (!m_nvb) @(posedge clk_48m);
		while (m_nvb) @(posedge clk_48m);
	endtask

	task automatic spin_pulse(input logic down);
		@(negedge clk_48m);
		ctrl.spinner = {down, 1'b1};
		@(negedge clk_48m);
		ctrl.spinner = {down, 1'b0};
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s finished, errors so far %0d", tests, name, errors);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [7:0] rd_val;
		logic [9:0] wa;
		logic b;
		logic dir;
		int net;
		int n;
		bus = '0;
		ctrl = '0;
		vram_access = 1'b0;
		tile_en = 1'b0;
		tb_hflip = 1'b0;
		tb_vflip = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		tile_checks = 0;
		cycles = 0;
		void'($urandom(36));
		wait (rst_n);

		// Fill every tile word and then read back a random sample
		for (int i = 0; i < 1024; i++) begin
			vmem[i] = 16'($urandom());
			bus_write(16'hE000 | 16'(i << 1), vmem[i][15:8]);
			bus_write(16'hE001 | 16'(i << 1), vmem[i][7:0]);
		end
		for (int i = 0; i < 64; i++) begin
			wa = 10'($urandom());
			b = 1'($urandom());
			bus_read(16'hE000 | 16'({wa, b}), rd_val);
			check_val("cpu_rdata_o", 16'(b ? vmem[wa][7:0] : vmem[wa][15:8]), 16'(rd_val));
		end
		report_test("video RAM write and read");

		// Every flip combination for three lines each
		for (int f = 0; f < 4; f++) begin
			tile_en = 1'b0;
			tb_hflip = f[0];
			tb_vflip = f[1];
			bus_write(16'hD008, {6'd0, tb_vflip, tb_hflip});
			repeat (32) @(negedge clk_48m);
			tile_en = 1'b1;
			repeat (3 * LINE_CLKS) @(negedge clk_48m);
		end
		tile_en = 1'b0;
		if (tile_checks == 0) begin
			$display("No graphics address load was checked during the tile test");
			errors++;
		end
		report_test("tile fetch with flips");

		// Button ports with random levels
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_48m);
			ctrl = {7'($urandom()), 2'b00};
			bus_read(16'hD00C, rd_val);
			check_val("button port 1", {8'h00, 2'b01, ctrl.coin2, ctrl.coin1, ctrl.tilt,
				ctrl.service, ctrl.start2, ctrl.start1}, 16'(rd_val));
			bus_read(16'hD008, rd_val);
			check_val("button port 1 low", 16'hFF, 16'(rd_val));
			bus_read(16'hD010, rd_val);
			check_val("button port 2", {8'h00, 5'b11111, ctrl.shot, 1'b1, ctrl.shot},
				16'(rd_val));
			bus_read(16'hD000, rd_val);
			check_val("unselected read", 16'hFF, 16'(rd_val));
		end
		// Spinner counts from zero after reset
		net = 0;
		n = 8 + ($urandom() % 24);
		for (int i = 0; i < n; i++) begin
			dir = 1'($urandom());
			spin_pulse(dir);
			net = dir ? net - 1 : net + 1;
		end
		repeat (24) @(posedge clk_48m);
		bus_read(16'hD018, rd_val);
		check_val("spinner", 16'(net[7:0]), 16'(rd_val));
		report_test("buttons and spinner");

		// Clear the request left over from the first frame
		pulse_iack();
		bus_write(16'hD010, 8'h00);
		wait_nvb_rise();
		check_val("cpu_int_n_o before", 16'h1, 16'(cpu_int_n));
		@(posedge clk_48m);
		check_val("cpu_int_n_o after rise", 16'h0, 16'(cpu_int_n));
		bus_write(16'hD010, 8'h00);
		pulse_iack();
		@(posedge clk_48m);
		check_val("cpu_int_n_o after iack", 16'h1, 16'(cpu_int_n));
		// No second request inside the same frame
		wait_nvb_fall();
		check_val("cpu_int_n_o at vblank", 16'h1, 16'(cpu_int_n));
		report_test("vblank interrupt");

		// One frame with clearing before the watchdog is left to run out
		bus_write(16'hD010, 8'h00);
		wait_nvb_fall();
		repeat (2) @(posedge clk_48m);
		check_val("cpu_reset_n_o cleared", 16'h1, 16'(cpu_reset_n));
		bus_write(16'hD010, 8'h00);
		for (int k = 1; k <= 4; k++) begin
			wait_nvb_fall();
			repeat (2) @(posedge clk_48m);
			check_val("cpu_reset_n_o", 16'(k < 4), 16'(cpu_reset_n));
		end
		report_test("watchdog");

		// The sync and blanking checks ran in the check block for the whole run
		report_test("sync and blanking monitor");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== src/ark_cpu_pkg.sv ====
// CPU-side types for the bus, the decoded video RAM request, the player controls and the latch
package ark_cpu_pkg;

	`include "ark_defines.svh"

	// Plain CPU bus, all strobes active high levels
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic rd;
		logic wr;
		logic iack;
	} cpu_bus_t;

	// Video RAM access decoded from the bus
	typedef struct packed {
		logic [`ARK_VRAM_AW-1:0] addr;
		// Byte select 0 picks bits 15:8 and 1 picks bits 7:0
		logic byte_sel;
		logic rd;
		logic wr;
	} vram_req_t;

	// Cabinet controls as they arrive at the board
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic shot;
		logic service;
		logic tilt;
		logic start1;
		logic start2;
		// Bit 0 is the count clock and bit 1 the direction
		logic [1:0] spinner;
	} ctrl_in_t;

	// Main latch bits still used by the video side
	typedef struct packed {
		logic vflip;
		logic hflip;
	} main_latch_t;

endpackage

// ==== src/ark_defines.svh ====
// Beam limits, pixel phase, CPU address map and memory sizes shared by the core RTL
`ifndef ARK_DEFINES_SVH
`define ARK_DEFINES_SVH

// ============================================================
// Beam counter limits
// ============================================================

// Horizontal counter reloads here after the last count
`define ARK_H_START 9'd128
`define ARK_H_END 9'd511

// Vertical limits before the centering offset is subtracted
`define ARK_V_BASE 9'd248
`define ARK_V_END_BASE 9'd511

// Value of the 3-bit divider at which the beam advances one pixel
`define ARK_PIX_PHASE 3'd4

// ============================================================
// Memory sizes and CPU address map
// ============================================================

// Video RAM holds 2K words, so 11 word address bits
`define ARK_VRAM_AW 11

// Upper address nibble of each decoded region
`define ARK_REG_VRAM 4'hE
`define ARK_REG_IO 4'hD

// I/O select codes taken from address bits 4:3
`define ARK_IO_LATCH 2'd1
`define ARK_IO_WDOG 2'd2
`define ARK_IO_SPIN 2'd3

`endif

// ==== src/ark_video_pkg.sv ====
// Video-side types for the beam position, the sync outputs and the tile-fetch result
package ark_video_pkg;

	// One 9-bit beam count, shared by the horizontal and vertical counters
	typedef logic [8:0] beam_cnt_t;

	// Beam state broadcast from the timing generator to every peer
	typedef struct packed {
		beam_cnt_t h_cnt;
		beam_cnt_t v_cnt;
		// High for one clock at each pixel step
		logic pix_cen;
		// Game vblank, low during the vertical blanking interval
		logic n_vblank;
	} beam_t;

	// Sync and blanking outputs, hsync and blanks active high, vsync active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic csync;
		logic hblank;
		logic vblank;
	} sync_out_t;

	// Graphics ROM address, tile code followed by the line within the tile
	typedef struct packed {
		logic [10:0] code;
		logic [2:0] line;
	} gfx_addr_t;

endpackage

// ==== src/arkanoid_core.sv ====
// Core top level, wires the beam timing, video RAM arbiter, tile fetcher, CPU I/O and supervisor
`timescale 1ns/1ns

`include "ark_defines.svh"

module arkanoid_core import ark_video_pkg::*, ark_cpu_pkg::*; #(
	parameter int WDOG_BITS = 8
) (
	input logic clk_48m,
	input logic rst_n_i,
	input logic [2:0] v_center_i,
	input cpu_bus_t bus_i,
	input ctrl_in_t ctrl_i,
	output logic [7:0] cpu_rdata_o,
	output logic cpu_wait_n_o,
	output logic cpu_int_n_o,
	output logic cpu_reset_n_o,
	output sync_out_t sync_o,
	output gfx_addr_t gfx_addr_o
);

	beam_t beam;
	vram_req_t vram_req;
	logic [7:0] vram_rdata;
	logic vram_busy;
	logic [`ARK_VRAM_AW-1:0] vid_addr;
	logic [15:0] vid_data;
	main_latch_t latch;
	logic wdog_clr;

	video_timing video_timing_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n_i),
		.v_center_i(v_center_i),
		.beam_o(beam),
		.sync_o(sync_o)
	);

	vram_arbiter vram_arbiter_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n_i),
		.beam_i(beam),
		.cpu_req_i(vram_req),
		.cpu_wdata_i(bus_i.wdata),
		.cpu_rdata_o(vram_rdata),
		.cpu_busy_o(vram_busy),
		.vid_addr_i(vid_addr),
		.vid_data_o(vid_data)
	);

	tile_fetch tile_fetch_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n_i),
		.beam_i(beam),
		.latch_i(latch),
		.vid_addr_o(vid_addr),
		.vid_data_i(vid_data),
		.gfx_addr_o(gfx_addr_o)
	);

	cpu_io cpu_io_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n_i),
		.cpu_reset_n_i(cpu_reset_n_o),
		.bus_i(bus_i),
		.ctrl_i(ctrl_i),
		.beam_i(beam),
		.vram_req_o(vram_req),
		.vram_rdata_i(vram_rdata),
		.rdata_o(cpu_rdata_o),
		.latch_o(latch),
		.wdog_clr_o(wdog_clr)
	);

	cpu_supervisor #(
		.WDOG_BITS(WDOG_BITS)
	) cpu_supervisor_i (
		.clk_48m(clk_48m),
		.rst_n_i(rst_n_i),
		.beam_i(beam),
		.iack_i(bus_i.iack),
		.wdog_clr_i(wdog_clr),
		.int_n_o(cpu_int_n_o),
		.cpu_reset_n_o(cpu_reset_n_o)
	);

	// The CPU waits while the video RAM is held by the fetcher
	assign cpu_wait_n_o = ~vram_busy;

endmodule

// ==== src/cpu_io.sv ====
// CPU address decoder with read multiplexer, main latch, button ports and spinner counter
`timescale 1ns/1ns

`include "ark_defines.svh"

module cpu_io import ark_video_pkg::*, ark_cpu_pkg::*; (
	input logic clk_48m,
	input logic rst_n_i,
	input logic cpu_reset_n_i,
	input cpu_bus_t bus_i,
	input ctrl_in_t ctrl_i,
	input beam_t beam_i,
	output vram_req_t vram_req_o,
	input logic [7:0] vram_rdata_i,
	output logic [7:0] rdata_o,
	output main_latch_t latch_o,
	output logic wdog_clr_o
);

	logic region_vram;
	logic region_io;
	logic [1:0] io_sel;
	logic latch_wr;
	logic wdog_wr;
	logic wdog_wr_q;
	logic [7:0] buttons_a;
	logic [7:0] buttons_b;
	logic [7:0] io_rdata;
	logic [7:0] spin_cnt;
	logic [7:0] spin_snap;
	logic old_spin_clk;
	logic old_h0;
	main_latch_t latch_q;

	// ============================================================
	// Address decode
	// ============================================================

	assign region_vram = (bus_i.addr[15:12] == `ARK_REG_VRAM);
	assign region_io = (bus_i.addr[15:12] == `ARK_REG_IO);
	assign io_sel = bus_i.addr[4:3];

	// Word address from the upper bits, byte from bit 0
	assign vram_req_o.addr = bus_i.addr[`ARK_VRAM_AW:1];
	assign vram_req_o.byte_sel = bus_i.addr[0];
	assign vram_req_o.rd = region_vram & bus_i.rd;
	assign vram_req_o.wr = region_vram & bus_i.wr;

	// ============================================================
	// Read multiplexer
	// ============================================================

	// Start and coin port only answers when address bit 2 is set
	assign buttons_a = bus_i.addr[2]
		? {2'b01, ctrl_i.coin2, ctrl_i.coin1, ctrl_i.tilt, ctrl_i.service,
			ctrl_i.start2, ctrl_i.start1}
		: 8'hFF;
	// Fire button appears twice on this port
	assign buttons_b = {5'b11111, ctrl_i.shot, 1'b1, ctrl_i.shot};

	always_comb begin
		case (io_sel)
			`ARK_IO_LATCH: io_rdata = buttons_a;
			`ARK_IO_WDOG: io_rdata = buttons_b;
			`ARK_IO_SPIN: io_rdata = spin_snap;
			default: io_rdata = 8'hFF;
		endcase
	end

	// Nothing selected reads as a floating bus
	assign rdata_o = !bus_i.rd ? 8'hFF :
		region_vram ? vram_rdata_i :
		region_io ? io_rdata : 8'hFF;

	// ============================================================
	// Writes
	// ============================================================

	assign latch_wr = region_io & bus_i.wr & (io_sel == `ARK_IO_LATCH);
	assign wdog_wr = region_io & bus_i.wr & (io_sel == `ARK_IO_WDOG);

	// The latch follows the CPU reset so a watchdog reset clears the flips
	always_ff @(posedge clk_48m) begin
		if (!cpu_reset_n_i) begin
			latch_q <= '0;
		end else if (beam_i.pix_cen && latch_wr) begin
			latch_q.vflip <= bus_i.wdata[1];
			latch_q.hflip <= bus_i.wdata[0];
		end
	end

	assign latch_o = latch_q;

	// One clear pulse per watchdog write
	assign wdog_clr_o = wdog_wr & ~wdog_wr_q;

	// ============================================================
	// Spinner
	// ============================================================

	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			wdog_wr_q <= 1'b0;
			old_spin_clk <= 1'b0;
			old_h0 <= 1'b0;
			spin_cnt <= 8'd0;
			spin_snap <= 8'd0;
		end else begin
			wdog_wr_q <= wdog_wr;
			old_spin_clk <= ctrl_i.spinner[0];
			old_h0 <= beam_i.h_cnt[0];
			// Count on the falling clock, up while the direction bit is low
			if (old_spin_clk && !ctrl_i.spinner[0]) begin
				spin_cnt <= ctrl_i.spinner[1] ? spin_cnt - 8'd1 : spin_cnt + 8'd1;
			end
			// Snapshot so the CPU never reads a count mid-change
			if (!old_h0 && beam_i.h_cnt[0]) begin
				spin_snap <= spin_cnt;
			end
		end
	end

endmodule

// ==== src/cpu_supervisor.sv ====
// CPU supervisor, raises the vblank interrupt and holds the CPU in reset on watchdog expiry
`timescale 1ns/1ns

module cpu_supervisor import ark_video_pkg::*; #(
	parameter int WDOG_BITS = 8
) (
	input logic clk_48m,
	input logic rst_n_i,
	input beam_t beam_i,
	input logic iack_i,
	input logic wdog_clr_i,
	output logic int_n_o,
	output logic cpu_reset_n_o
);

	logic old_nvblank;
	logic nvblank_rise;
	logic nvblank_fall;
	logic int_n_q;
	logic [WDOG_BITS-1:0] wdog_cnt;

	assign nvblank_rise = !old_nvblank && beam_i.n_vblank;
	assign nvblank_fall = old_nvblank && !beam_i.n_vblank;

	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			old_nvblank <= 1'b1;
			int_n_q <= 1'b1;
			wdog_cnt <= '0;
		end else begin
			old_nvblank <= beam_i.n_vblank;
			// Acknowledge wins over a new request in the same clock
			if (iack_i) begin
				int_n_q <= 1'b1;
			end else if (nvblank_rise) begin
				int_n_q <= 1'b0;
			end
			// Watchdog counts frames until the game clears it
			if (wdog_clr_i) begin
				wdog_cnt <= '0;
			end else if (nvblank_fall) begin
				wdog_cnt <= wdog_cnt + 1'b1;
			end
		end
	end

	assign int_n_o = int_n_q;
	assign cpu_reset_n_o = rst_n_i & ~wdog_cnt[WDOG_BITS-1];

endmodule

// ==== src/tile_fetch.sv ====
// Tile fetcher, forms flip-adjusted video RAM addresses and latches graphics ROM addresses
`timescale 1ns/1ns

`include "ark_defines.svh"

module tile_fetch import ark_video_pkg::*, ark_cpu_pkg::*; (
	input logic clk_48m,
	input logic rst_n_i,
	input beam_t beam_i,
	input main_latch_t latch_i,
	output logic [`ARK_VRAM_AW-1:0] vid_addr_o,
	input logic [15:0] vid_data_i,
	output gfx_addr_t gfx_addr_o
);

	beam_cnt_t h_x;
	beam_cnt_t v_x;
	logic old_h0;
	gfx_addr_t gfx_q;

	// Flip simply inverts the beam counts
	assign h_x = beam_i.h_cnt ^ {9{latch_i.hflip}};
	assign v_x = beam_i.v_cnt ^ {9{latch_i.vflip}};

	// Tile row from v and tile column from h, only in the active region
	assign vid_addr_o = beam_i.h_cnt[8] ? {1'b0, v_x[7:3], h_x[7:3]} : '0;

	// The word fetched during the odd step is latched once h turns even
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			old_h0 <= 1'b0;
			gfx_q <= '0;
		end else begin
			old_h0 <= beam_i.h_cnt[0];
			if (old_h0 && !beam_i.h_cnt[0] && beam_i.h_cnt[8]) begin
				gfx_q.code <= vid_data_i[10:0];
				gfx_q.line <= v_x[2:0];
			end
		end
	end

	assign gfx_addr_o = gfx_q;

endmodule

// ==== src/video_timing.sv ====
// Beam timing generator, makes the pixel step, beam counters, sync, blanking and game vblank
`timescale 1ns/1ns

`include "ark_defines.svh"

module video_timing import ark_video_pkg::*; (
	input logic clk_48m,
	input logic rst_n_i,
	input logic [2:0] v_center_i,
	output beam_t beam_o,
	output sync_out_t sync_o
);

	// Sync and blanking windows in beam counts
	localparam logic [6:0] HS_LO = 7'd47;
	localparam logic [6:0] HS_HI = 7'd80;
	localparam beam_cnt_t HB_LO = 9'd137;
	localparam beam_cnt_t HB_HI = 9'd266;
	localparam beam_cnt_t VB_LO = 9'd271;
	localparam beam_cnt_t VB_HI = 9'd495;

	logic [2:0] div;
	logic pix_cen;
	beam_cnt_t h_cnt;
	beam_cnt_t v_cnt;
	beam_cnt_t v_start;
	beam_cnt_t v_end;
	logic old_v4;
	logic n_vblank;

	// Centering moves both the reload and the wrap point up by the same amount
	assign v_start = `ARK_V_BASE - {6'd0, v_center_i};
	assign v_end = `ARK_V_END_BASE - {6'd0, v_center_i};

	// One pixel step in every eight clocks
	assign pix_cen = (div == `ARK_PIX_PHASE);

	// ============================================================
	// Beam counters
	// ============================================================

	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			div <= 3'd0;
			h_cnt <= `ARK_H_START;
			v_cnt <= v_start;
		end else begin
			div <= div + 3'd1;
			if (pix_cen) begin
				if (h_cnt == `ARK_H_END) begin
					h_cnt <= `ARK_H_START;
				end else begin
					h_cnt <= h_cnt + 9'd1;
				end
				// The line advances as h leaves its reload value
				if (h_cnt == `ARK_H_START) begin
					if (v_cnt == v_end) begin
						v_cnt <= v_start;
					end else begin
						v_cnt <= v_cnt + 9'd1;
					end
				end
			end
		end
	end

	// Game vblank samples the top line bits each time v bit 4 rises
	// so it drops at line 496 and returns on the first rise after the wrap
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			old_v4 <= 1'b1;
			n_vblank <= 1'b1;
		end else begin
			old_v4 <= v_cnt[4];
			if (!old_v4 && v_cnt[4]) begin
				n_vblank <= ~(&v_cnt[7:5]);
			end
		end
	end

	// ============================================================
	// Outputs
	// ============================================================

	assign beam_o.h_cnt = h_cnt;
	assign beam_o.v_cnt = v_cnt;
	assign beam_o.pix_cen = pix_cen;
	assign beam_o.n_vblank = n_vblank;

	assign sync_o.hsync = ~h_cnt[8] && (h_cnt[6:0] > HS_LO) && (h_cnt[6:0] < HS_HI);
	// Vsync is low for the first eight lines of the frame
	assign sync_o.vsync = ~((v_cnt >= v_start) && (v_cnt <= v_start + 9'd7));
	assign sync_o.csync = sync_o.hsync ^ sync_o.vsync;
	assign sync_o.hblank = (h_cnt > HB_LO) && (h_cnt < HB_HI);
	assign sync_o.vblank = (v_cnt < VB_LO) || (v_cnt > VB_HI);

endmodule

// ==== src/vram_arbiter.sv ====
// Video RAM with two byte banks, shared between the CPU and the tile fetcher by h parity
`timescale 1ns/1ns

`include "ark_defines.svh"

module vram_arbiter import ark_video_pkg::*, ark_cpu_pkg::*; (
	input logic clk_48m,
	input logic rst_n_i,
	input beam_t beam_i,
	input vram_req_t cpu_req_i,
	input logic [7:0] cpu_wdata_i,
	output logic [7:0] cpu_rdata_o,
	output logic cpu_busy_o,
	input logic [`ARK_VRAM_AW-1:0] vid_addr_i,
	output logic [15:0] vid_data_o
);

	localparam int VRAM_DEPTH = 1 << `ARK_VRAM_AW;

	// Bank hi holds bits 15:8 of each word and bank lo bits 7:0
	logic [7:0] bank_hi [VRAM_DEPTH];
	logic [7:0] bank_lo [VRAM_DEPTH];
	logic [7:0] q_hi;
	logic [7:0] q_lo;
	logic [`ARK_VRAM_AW-1:0] ram_addr;
	logic cpu_phase;
	logic cpu_req;
	logic cpu_step;
	logic we_hi;
	logic we_lo;
	logic rd_done;
	logic rd_sel;
	logic [7:0] rdata_q;

	// ============================================================
	// Phase arbitration
	// ============================================================

	// The CPU owns even h and the fetcher owns odd h
	assign cpu_phase = ~beam_i.h_cnt[0];
	assign cpu_req = cpu_req_i.rd | cpu_req_i.wr;
	assign ram_addr = cpu_phase ? cpu_req_i.addr : vid_addr_i;

	// A CPU access completes on the pixel step that ends its even slot
	assign cpu_step = rst_n_i & beam_i.pix_cen & cpu_phase;
	assign we_hi = cpu_step & cpu_req_i.wr & ~cpu_req_i.byte_sel;
	assign we_lo = cpu_step & cpu_req_i.wr & cpu_req_i.byte_sel;

	// Hold the CPU off while the fetcher has the RAM
	assign cpu_busy_o = cpu_req & beam_i.h_cnt[0];

	// ============================================================
	// Byte banks
	// ============================================================

	always_ff @(posedge clk_48m) begin
		if (we_hi) begin
			bank_hi[ram_addr] <= cpu_wdata_i;
		end
		q_hi <= bank_hi[ram_addr];
	end

	always_ff @(posedge clk_48m) begin
		if (we_lo) begin
			bank_lo[ram_addr] <= cpu_wdata_i;
		end
		q_lo <= bank_lo[ram_addr];
	end

	// The word read at a completing step is in q on the next clock
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			rd_done <= 1'b0;
		end else begin
			rd_done <= cpu_step & cpu_req_i.rd;
		end
	end

	always_ff @(posedge clk_48m) begin
		if (cpu_step) begin
			rd_sel <= cpu_req_i.byte_sel;
		end
		if (rd_done) begin
			rdata_q <= rd_sel ? q_lo : q_hi;
		end
	end

	assign cpu_rdata_o = rdata_q;
	assign vid_data_o = {q_hi, q_lo};

endmodule

// ==== tb.f ====
+incdir+src
src/ark_video_pkg.sv
src/ark_cpu_pkg.sv
src/video_timing.sv
src/vram_arbiter.sv
src/tile_fetch.sv
src/cpu_io.sv
src/cpu_supervisor.sv
src/arkanoid_core.sv
sim/tb_clock.sv
sim/tb_top.sv
